/* bench/conv_layer_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

module conv_layer_asserts
    import conv_geom_pkg::*;
(
    input wire clk,
    input wire reset,
    input wire start_from_previous,
    input wire end_to_previous,
    input wire start_to_next,
    input wire end_from_next,
    input wire shift_en,
    input wire conv_en
);

    int fail_count = 0;

    // next layer must be ready first
    next_ready: assert property (@(posedge clk) disable iff (reset)
        (!end_to_previous && !end_from_next) |=> !end_to_previous)
        else
        begin
            $error("layer went idle while end_from_next was low");
            fail_count++;
        end

    start_busy: assert property (@(posedge clk) disable iff (reset)
        (end_to_previous && start_from_previous) |=> !end_to_previous)
        else
        begin
            $error("end_to_previous stayed high after a start");
            fail_count++;
        end

    idle_after_next: assert property (@(posedge clk) disable iff (reset)
        $rose(end_to_previous) |-> $past(start_to_next))
        else
        begin
            $error("end_to_previous rose without start_to_next");
            fail_count++;
        end

    // full window only after a whole fill of this pass
    window_fill: assert property (@(posedge clk) disable iff (reset)
        conv_en |-> $past(shift_en, FILL_COUNT - 1))
        else
        begin
            $error("conv_en high before the line buffer was filled");
            fail_count++;
        end

endmodule

`default_nettype wire

/* bench/conv_layer_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module conv_layer_checker
    import conv_geom_pkg::*;
    import conv_data_pkg::*;
(
    input  wire                  clk,
    input  wire                  ifm_we,
    input  wire [IFM_ADDR_W-1:0] ifm_addr,
    input  wire pixel_t          ifm_data,
    input  wire                  wt_we,
    input  wire [WT_ADDR_W-1:0]  wt_addr,
    input  wire pixel_t          wt_data,
    input  wire                  bias_we,
    input  wire [FILT_W-1:0]     bias_addr,
    input  wire acc_t            bias_data,
    input  wire                  check_en,
    input  wire [OFM_ADDR_W-1:0] ofm_rd_addr,
    input  wire acc_t            ofm_rd_data,
    output int                   error_count,
    output int                   check_count,
    output int                   zero_count,
    output int                   pos_count
);

    pixel_t                ifm_ref [IFM_DEPTH*IFM_PIXELS];
    pixel_t                wt_ref [NUM_FILTERS*IFM_DEPTH*KERNEL_TAPS];
    acc_t                  bias_ref [NUM_FILTERS];
    logic                  rd_pending = 1'b0;
    logic [OFM_ADDR_W-1:0] rd_addr_q = '0;
    acc_t                  expected;
    int                    errors = 0;
    int                    checks = 0;
    int                    zeros = 0;
    int                    positives = 0;

    assign error_count = errors;
    assign check_count = checks;
    assign zero_count  = zeros;
    assign pos_count   = positives;

    // bias, then products over all channels and taps, then relu
    function automatic acc_t expected_ofm(input int addr);
        int   f;
        int   row;
        int   col;
        acc_t total;
        f     = addr / OFM_PIXELS;
        row   = (addr % OFM_PIXELS) / OFM_SIZE;
        col   = (addr % OFM_PIXELS) % OFM_SIZE;
        total = bias_ref[f];
        for (int ch = 0; ch < IFM_DEPTH; ch++)
            for (int kr = 0; kr < KERNEL_SIZE; kr++)
                for (int kc = 0; kc < KERNEL_SIZE; kc++)
                    total = total
                        + acc_t'(ifm_ref[ch*IFM_PIXELS + (row+kr)*IFM_SIZE + col + kc])
                        * acc_t'(wt_ref[(f*IFM_DEPTH + ch)*KERNEL_TAPS + kr*KERNEL_SIZE + kc]);
        if (total < 0)
            total = '0;
        return total;
    endfunction

    ////////////////////////////////////////
    // mirror of the load ports
    ////////////////////////////////////////
    always @(posedge clk)
    begin
        if (ifm_we)
            ifm_ref[ifm_addr] <= ifm_data;
        if (wt_we)
            wt_ref[wt_addr] <= wt_data;
        if (bias_we)
            bias_ref[bias_addr] <= bias_data;
        rd_pending <= check_en;   // read data lands one cycle later
        rd_addr_q  <= ofm_rd_addr;
    end

    always @(negedge clk)
    begin
        if (rd_pending)
        begin
            expected = expected_ofm(int'(rd_addr_q));
            checks++;
            if (ofm_rd_data == 0)
                zeros++;
            else if (ofm_rd_data > 0)
                positives++;
            if (ofm_rd_data !== expected)
            begin
                errors++;
                $display("error at %0t: ofm[%0d] read %0d, expected %0d",
                         $time, rd_addr_q, ofm_rd_data, expected);
            end
        end
    end

endmodule

`default_nettype wire

/* bench/conv_layer_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module conv_layer_tb
    import conv_geom_pkg::*;
    import conv_data_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int NUM_RUNS     = 5;
    localparam int LAYER_CYCLES = NUM_FILTERS * IFM_DEPTH * (IFM_PIXELS + MAC_LATENCY + 2) + 4;
    localparam int LOAD_CYCLES  = IFM_DEPTH*IFM_PIXELS + NUM_FILTERS*IFM_DEPTH*KERNEL_TAPS
                                  + NUM_FILTERS + 3;
    localparam int READ_CYCLES  = NUM_FILTERS * OFM_PIXELS + 2;
    localparam int HOLD_MAX     = 40;
    localparam int WATCHDOG_CYCLES = NUM_RUNS * (LOAD_CYCLES + 2*LAYER_CYCLES + READ_CYCLES
                                     + HOLD_MAX + 10) + 100;

    logic                  clk;
    logic                  reset;
    logic                  ifm_we;
    logic [IFM_ADDR_W-1:0] ifm_addr;
    pixel_t                ifm_data;
    logic                  wt_we;
    logic [WT_ADDR_W-1:0]  wt_addr;
    pixel_t                wt_data;
    logic                  bias_we;
    logic [FILT_W-1:0]     bias_addr;
    acc_t                  bias_data;
    logic                  start_from_previous;
    logic                  end_to_previous;
    logic                  start_to_next;
    logic                  end_from_next;
    logic [OFM_ADDR_W-1:0] ofm_rd_addr;
    acc_t                  ofm_rd_data;
    logic                  check_en;
    logic                  stn_seen;
    int                    error_count;
    int                    check_count;
    int                    zero_count;
    int                    pos_count;
    int                    flow_errors = 0;
    int                    assert_errors;
    int                    zeros_before;
    int                    pos_before;

    conv_layer i_dut (.*);

    conv_layer_checker i_checker (.*);

    bind conv_layer conv_layer_asserts i_asserts
    (
        .clk                 (clk),
        .reset               (reset),
        .start_from_previous (start_from_previous),
        .end_to_previous     (end_to_previous),
        .start_to_next       (start_to_next),
        .end_from_next       (end_from_next),
        .shift_en            (cif.shift_en),
        .conv_en             (cif.conv_en)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // start_to_next can be high for only half a cycle after a late end_from_next
    always @(posedge clk or posedge reset)
    begin
        if (reset)
            stn_seen <= 1'b0;
        else
            stn_seen <= start_to_next;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: layer runs did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

    function automatic int small_rand();
        return int'($urandom_range(0, 15)) - 8;
    endfunction

    ////////////////////////////////////////
    // loading
    ////////////////////////////////////////
    task automatic load_maps_weights();
        for (int a = 0; a < IFM_DEPTH*IFM_PIXELS; a++)
        begin
            @(negedge clk);
            ifm_we   = 1'b1;
            ifm_addr = IFM_ADDR_W'(a);
            ifm_data = pixel_t'(small_rand());
        end
        @(negedge clk);
        ifm_we = 1'b0;
        for (int a = 0; a < NUM_FILTERS*IFM_DEPTH*KERNEL_TAPS; a++)
        begin
            @(negedge clk);
            wt_we   = 1'b1;
            wt_addr = WT_ADDR_W'(a);
            wt_data = pixel_t'(small_rand());
        end
        @(negedge clk);
        wt_we = 1'b0;
    endtask

    // split_sign gives even filters a large negative bias, odd ones a large positive
    task automatic load_biases(input bit split_sign);
        for (int f = 0; f < NUM_FILTERS; f++)
        begin
            @(negedge clk);
            bias_we   = 1'b1;
            bias_addr = FILT_W'(f);
            if (split_sign)
                bias_data = (f % 2 == 0) ? -2000 : 2000;
            else
                bias_data = acc_t'(small_rand() * 16);
        end
        @(negedge clk);
        bias_we = 1'b0;
    endtask

    ////////////////////////////////////////
    // layer handshake
    ////////////////////////////////////////
    task automatic run_layer(input int hold, input int mid_start);
        int n;
        bit done;
        n    = 0;
        done = 1'b0;
        @(negedge clk);
        if (!end_to_previous)
        begin
            $display("layer is not idle before the start pulse at %0t", $time);
            flow_errors++;
        end
        start_from_previous = 1'b1;
        while (!done)
        begin
            @(negedge clk);
            if (stn_seen)
            begin
                done = 1'b1;
                if (hold >= 0 && n <= hold)
                begin
                    $display("start_to_next came before end_from_next rose at %0t", $time);
                    flow_errors++;
                end
                if (!end_to_previous)
                begin
                    $display("end_to_previous did not rise after start_to_next at %0t", $time);
                    flow_errors++;
                end
            end
            else if (end_to_previous)
            begin
                $display("end_to_previous rose before start_to_next at %0t", $time);
                flow_errors++;
                done = 1'b1;
            end
            start_from_previous = (n == mid_start);
            if (n == hold)
                end_from_next = 1'b1;   // release back pressure
            n++;
        end
        start_from_previous = 1'b0;
    endtask

    task automatic read_results();
        for (int a = 0; a < NUM_FILTERS*OFM_PIXELS; a++)
        begin
            @(negedge clk);
            check_en    = 1'b1;
            ofm_rd_addr = OFM_ADDR_W'(a);
        end
        @(negedge clk);
        check_en = 1'b0;
        @(negedge clk);
    endtask

    initial
    begin
        void'($urandom(46960));
        reset               = 1'b1;
        ifm_we              = 1'b0;
        ifm_addr            = '0;
        ifm_data            = '0;
        wt_we               = 1'b0;
        wt_addr             = '0;
        wt_data             = '0;
        bias_we             = 1'b0;
        bias_addr           = '0;
        bias_data           = '0;
        start_from_previous = 1'b0;
        end_from_next       = 1'b1;
        ofm_rd_addr         = '0;
        check_en            = 1'b0;
        repeat (10) @(negedge clk);
        reset = 1'b0;

        // random layer
        load_maps_weights();
        load_biases(1'b0);
        run_layer(-1, -1);
        read_results();

        // relu on clamped and positive outputs
        load_maps_weights();
        load_biases(1'b1);
        zeros_before = zero_count;
        pos_before   = pos_count;
        run_layer(-1, -1);
        read_results();
        if (zero_count == zeros_before || pos_count == pos_before)
        begin
            $display("relu run did not give both clamped and positive outputs");
            flow_errors++;
        end

        // back pressure from the next layer
        load_maps_weights();
        load_biases(1'b0);
        @(negedge clk);
        end_from_next = 1'b0;
        run_layer(LAYER_CYCLES + int'($urandom_range(5, HOLD_MAX)), -1);
        read_results();

        // stray start while busy
        run_layer(-1, 60);
        repeat (5)
        begin
            @(negedge clk);
            if (!end_to_previous)
            begin
                $display("a start pulse during the run started another layer");
                flow_errors++;
            end
        end
        read_results();

        // fresh data, nothing carried over
        load_maps_weights();
        load_biases(1'b0);
        run_layer(-1, -1);
        read_results();

        if (check_count != NUM_RUNS * NUM_FILTERS * OFM_PIXELS)
        begin
            $display("only %0d of %0d results were checked", check_count,
                     NUM_RUNS * NUM_FILTERS * OFM_PIXELS);
            flow_errors++;
        end

        assert_errors = i_dut.i_asserts.fail_count;
        $display("summary: %0d result, %0d handshake, %0d assertion errors, %0d checked",
                 error_count, flow_errors, assert_errors, check_count);
        if (error_count == 0 && flow_errors == 0 && assert_errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module conv_layer_tb -o conv_layer_sim -f src.f || exit 1
out=$(./obj_dir/conv_layer_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'All tests passed!' && exit 0 || exit 1

/* src.f */
src/conv_geom_pkg.sv
src/conv_data_pkg.sv
src/conv_ctrl_if.sv
src/conv_ctrl.sv
src/window_buffer.sv
src/conv_mac.sv
src/psum_accum.sv
src/conv_layer.sv
bench/conv_layer_checker.sv
bench/conv_layer_asserts.sv
bench/conv_layer_tb.sv

/* src/conv_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module conv_ctrl
    import conv_geom_pkg::*;
    import conv_data_pkg::*;
(
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   start_from_previous,
    output logic                  end_to_previous,
    input  wire                   end_from_next,
    output logic                  start_to_next,
    output logic                  ifm_rd_en,
    output logic [IFM_ADDR_W-1:0] ifm_rd_addr,
    conv_ctrl_if.ctrl             ctrl
);

    enum logic [1:0] {IDLE, READ, DRAIN, WAIT_NEXT} state, state_next;
    enum logic [1:0] {W_FILL, W_READY, W_GAP} wstate;

    logic [PIX_ADDR_W-1:0] pix_cnt;
    logic [CHAN_W-1:0]     chan_cnt;
    logic [FILT_W-1:0]     filt_cnt;
    logic [DRAIN_W-1:0]    drain_cnt;
    logic                  pix_last;
    logic                  chan_last;
    logic                  filt_last;
    logic                  drain_last;
    logic [FILL_W-1:0]     fill_cnt;
    logic [ROW_W-1:0]      row_cnt;
    logic                  shift_en;
    logic                  conv_en;
    logic [MAC_LATENCY:0]  we_pipe;
    logic                  psum_we;
    logic [OFM_POS_W-1:0]  ofm_pos;

    assign pix_last   = (pix_cnt == PIX_ADDR_W'(IFM_PIXELS - 1));
    assign chan_last  = (chan_cnt == CHAN_W'(IFM_DEPTH - 1));
    assign filt_last  = (filt_cnt == FILT_W'(NUM_FILTERS - 1));
    assign drain_last = (drain_cnt == DRAIN_W'(MAC_LATENCY + 1));

    ////////////////////////////////////////
    // pass FSM
    ////////////////////////////////////////
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= IDLE;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:
                if (start_from_previous)
                    state_next = READ;
            READ:
                if (pix_last)
                    state_next = DRAIN;
            DRAIN:   // last write lands on the final drain cycle
                if (drain_last)
                    state_next = (chan_last && filt_last) ? WAIT_NEXT : READ;
            WAIT_NEXT:
                if (end_from_next)
                    state_next = IDLE;
            default:
                state_next = IDLE;
        endcase
    end

    assign end_to_previous = (state == IDLE);
    assign start_to_next   = (state == WAIT_NEXT) && end_from_next;
    assign ifm_rd_en       = (state == READ);
    assign ifm_rd_addr     = IFM_ADDR_W'(chan_cnt) * IFM_ADDR_W'(IFM_PIXELS)
                             + IFM_ADDR_W'(pix_cnt);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            pix_cnt   <= '0;
            drain_cnt <= '0;
            chan_cnt  <= '0;
            filt_cnt  <= '0;
        end
        else
        begin
            if (state == READ)
                pix_cnt <= pix_last ? '0 : pix_cnt + 1'b1;
            drain_cnt <= (state == DRAIN) ? drain_cnt + 1'b1 : '0;
            if (state == DRAIN && drain_last)
            begin
                chan_cnt <= chan_last ? '0 : chan_cnt + 1'b1;
                if (chan_last)
                    filt_cnt <= filt_last ? '0 : filt_cnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // window valid FSM
    ////////////////////////////////////////
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            shift_en <= 1'b0;
        else
            shift_en <= ifm_rd_en;   // map read latency
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            wstate   <= W_FILL;
            fill_cnt <= '0;
            row_cnt  <= '0;
        end
        else if (!shift_en)
        begin
            wstate   <= W_FILL;
            fill_cnt <= '0;
            row_cnt  <= '0;
        end
        else
        begin
            case (wstate)
                W_FILL:
                begin
                    if (fill_cnt == FILL_W'(FILL_COUNT - 2))
                    begin
                        wstate   <= W_READY;
                        fill_cnt <= '0;
                    end
                    else
                        fill_cnt <= fill_cnt + 1'b1;
                end
                W_READY:
                begin
                    if (row_cnt == ROW_W'(OFM_SIZE - 1))
                    begin
                        wstate  <= W_GAP;
                        row_cnt <= '0;
                    end
                    else
                        row_cnt <= row_cnt + 1'b1;
                end
                W_GAP:   // window wraps across the row edge
                begin
                    if (row_cnt == ROW_W'(KERNEL_SIZE - 2))
                    begin
                        wstate  <= W_READY;
                        row_cnt <= '0;
                    end
                    else
                        row_cnt <= row_cnt + 1'b1;
                end
                default:
                    wstate <= W_FILL;
            endcase
        end
    end

    assign conv_en = shift_en && (wstate == W_READY);

    // window reg plus mac pipeline
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            we_pipe <= '0;
        else
            we_pipe <= {we_pipe[MAC_LATENCY-1:0], conv_en};
    end

    assign psum_we = we_pipe[MAC_LATENCY];

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            ofm_pos <= '0;
        else if (psum_we)
            ofm_pos <= (ofm_pos == OFM_POS_W'(OFM_PIXELS - 1)) ? '0 : ofm_pos + 1'b1;
    end

    assign ctrl.shift_en   = shift_en;
    assign ctrl.conv_en    = conv_en;
    assign ctrl.filt_idx   = filt_cnt;
    assign ctrl.chan_idx   = chan_cnt;
    assign ctrl.first_chan = (chan_cnt == '0);
    assign ctrl.last_chan  = chan_last;
    assign ctrl.psum_we    = psum_we;
    assign ctrl.ofm_addr   = OFM_ADDR_W'(filt_cnt) * OFM_ADDR_W'(OFM_PIXELS)
                             + OFM_ADDR_W'(ofm_pos);

endmodule

`default_nettype wire

/* src/conv_ctrl_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface conv_ctrl_if
    import conv_geom_pkg::*;
();

    logic                  shift_en;   // line buffer advances
    logic                  conv_en;    // this shift completes a window
    logic [FILT_W-1:0]     filt_idx;
    logic [CHAN_W-1:0]     chan_idx;
    logic                  first_chan;
    logic                  last_chan;
    logic [OFM_ADDR_W-1:0] ofm_addr;
    logic                  psum_we;

    modport ctrl
    (
        output shift_en, conv_en, filt_idx, chan_idx,
        output first_chan, last_chan, ofm_addr, psum_we
    );

    modport window (input shift_en);
    modport mac (input filt_idx, chan_idx, conv_en);
    modport accum (input first_chan, last_chan, ofm_addr, psum_we, filt_idx);

endinterface

`default_nettype wire

/* src/conv_data_pkg.sv */
`default_nettype none

package conv_data_pkg;

    localparam int PIXEL_W = 16;
    localparam int ACC_W   = 32;

    // product register, then tree sum register
    localparam int MAC_LATENCY = 2;
    localparam int DRAIN_W     = $clog2(MAC_LATENCY + 2);

    typedef logic signed [PIXEL_W-1:0] pixel_t;   // pixels and weights

    // products, partial sums, biases, outputs
    typedef logic signed [ACC_W-1:0] acc_t;

endpackage

`default_nettype wire

/* src/conv_geom_pkg.sv */
`default_nettype none

package conv_geom_pkg;

    localparam int IFM_SIZE    = 6;
    localparam int KERNEL_SIZE = 3;
    localparam int IFM_DEPTH   = 2;
    localparam int NUM_FILTERS = 2;

    localparam int OFM_SIZE    = IFM_SIZE - KERNEL_SIZE + 1;
    localparam int IFM_PIXELS  = IFM_SIZE * IFM_SIZE;
    localparam int OFM_PIXELS  = OFM_SIZE * OFM_SIZE;
    localparam int KERNEL_TAPS = KERNEL_SIZE * KERNEL_SIZE;
    localparam int FILL_COUNT  = (KERNEL_SIZE - 1) * IFM_SIZE + KERNEL_SIZE;

    // index and counter widths
    localparam int FILT_W     = (NUM_FILTERS > 1) ? $clog2(NUM_FILTERS) : 1;
    localparam int CHAN_W     = (IFM_DEPTH > 1) ? $clog2(IFM_DEPTH) : 1;
    localparam int PIX_ADDR_W = $clog2(IFM_PIXELS);
    localparam int OFM_POS_W  = $clog2(OFM_PIXELS);
    localparam int FILL_W     = $clog2(FILL_COUNT);
    localparam int ROW_W      = $clog2(OFM_SIZE + KERNEL_SIZE);

    // maps are channel major, outputs and kernels filter major
    localparam int IFM_ADDR_W = $clog2(IFM_DEPTH * IFM_PIXELS);
    localparam int OFM_ADDR_W = $clog2(NUM_FILTERS * OFM_PIXELS);
    localparam int WT_ADDR_W  = $clog2(NUM_FILTERS * IFM_DEPTH * KERNEL_TAPS);

endpackage

`default_nettype wire

/* src/conv_layer.sv */
`timescale 1ns/100ps
`default_nettype none

module conv_layer
    import conv_geom_pkg::*;
    import conv_data_pkg::*;
(
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  ifm_we,
    input  wire [IFM_ADDR_W-1:0] ifm_addr,
    input  wire pixel_t          ifm_data,
    input  wire                  wt_we,
    input  wire [WT_ADDR_W-1:0]  wt_addr,
    input  wire pixel_t          wt_data,
    input  wire                  bias_we,
    input  wire [FILT_W-1:0]     bias_addr,
    input  wire acc_t            bias_data,
    input  wire                  start_from_previous,
    output logic                 end_to_previous,
    output logic                 start_to_next,
    input  wire                  end_from_next,
    input  wire [OFM_ADDR_W-1:0] ofm_rd_addr,
    output acc_t                 ofm_rd_data
);

    pixel_t                ifm_mem [IFM_DEPTH*IFM_PIXELS];
    pixel_t                ifm_rd_data;
    logic                  ifm_rd_en;
    logic [IFM_ADDR_W-1:0] ifm_rd_addr;
    pixel_t                window [KERNEL_TAPS];
    acc_t                  mac_sum;

    conv_ctrl_if cif ();

    ////////////////////////////////////////
    // input map memory
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (ifm_we)
            ifm_mem[ifm_addr] <= ifm_data;
        if (ifm_rd_en)
            ifm_rd_data <= ifm_mem[ifm_rd_addr];   // one cycle read latency
    end

    conv_ctrl i_ctrl
    (
        .clk                 (clk),
        .reset               (reset),
        .start_from_previous (start_from_previous),
        .end_to_previous     (end_to_previous),
        .end_from_next       (end_from_next),
        .start_to_next       (start_to_next),
        .ifm_rd_en           (ifm_rd_en),
        .ifm_rd_addr         (ifm_rd_addr),
        .ctrl                (cif.ctrl)
    );

    window_buffer i_window
    (
        .clk      (clk),
        .reset    (reset),
        .shift_in (ifm_rd_data),
        .win      (cif.window),
        .window   (window)
    );

    conv_mac i_mac
    (
        .clk     (clk),
        .reset   (reset),
        .wt_we   (wt_we),
        .wt_addr (wt_addr),
        .wt_data (wt_data),
        .window  (window),
        .mc      (cif.mac),
        .sum     (mac_sum)
    );

    psum_accum i_accum
    (
        .clk         (clk),
        .reset       (reset),
        .bias_we     (bias_we),
        .bias_addr   (bias_addr),
        .bias_data   (bias_data),
        .sum         (mac_sum),
        .acc         (cif.accum),
        .ofm_rd_addr (ofm_rd_addr),
        .ofm_rd_data (ofm_rd_data)
    );

endmodule

`default_nettype wire

/* src/conv_mac.sv */
`timescale 1ns/100ps
`default_nettype none

module conv_mac
    import conv_geom_pkg::*;
    import conv_data_pkg::*;
(
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 wt_we,
    input  wire [WT_ADDR_W-1:0] wt_addr,
    input  wire pixel_t         wt_data,
    input  wire pixel_t         window [KERNEL_TAPS],
    conv_ctrl_if.mac            mc,
    output acc_t                sum
);

    pixel_t               kern_mem [NUM_FILTERS*IFM_DEPTH*KERNEL_TAPS];
    logic [WT_ADDR_W-1:0] kern_base;
    acc_t                 prod [KERNEL_TAPS];
    acc_t                 tree_sum;
    logic                 win_valid;
    logic                 prod_valid;

    always_ff @(posedge clk)
    begin
        if (wt_we)
            kern_mem[wt_addr] <= wt_data;
    end

    // kernel of the current filter and channel
    assign kern_base = (WT_ADDR_W'(mc.filt_idx) * WT_ADDR_W'(IFM_DEPTH)
                        + WT_ADDR_W'(mc.chan_idx)) * WT_ADDR_W'(KERNEL_TAPS);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            win_valid  <= 1'b0;
            prod_valid <= 1'b0;
        end
        else
        begin
            win_valid  <= mc.conv_en;
            prod_valid <= win_valid;
        end
    end

    ////////////////////////////////////////
    // multiply and reduce
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (win_valid)
        begin
            for (int t = 0; t < KERNEL_TAPS; t++)
                prod[t] <= acc_t'(window[t]) * acc_t'(kern_mem[kern_base + WT_ADDR_W'(t)]);
        end
    end

    always_comb
    begin
        tree_sum = '0;
        for (int t = 0; t < KERNEL_TAPS; t++)
            tree_sum = tree_sum + prod[t];
    end

    always_ff @(posedge clk)
    begin
        if (prod_valid)
            sum <= tree_sum;
    end

endmodule

`default_nettype wire

/* src/psum_accum.sv */
`timescale 1ns/100ps
`default_nettype none

module psum_accum
    import conv_geom_pkg::*;
    import conv_data_pkg::*;
(
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  bias_we,
    input  wire [FILT_W-1:0]     bias_addr,
    input  wire acc_t            bias_data,
    input  wire acc_t            sum,
    conv_ctrl_if.accum           acc,
    input  wire [OFM_ADDR_W-1:0] ofm_rd_addr,
    output acc_t                 ofm_rd_data
);

    acc_t bias_mem [NUM_FILTERS];
    acc_t ofm_mem [NUM_FILTERS*OFM_PIXELS];
    acc_t psum_base;
    acc_t psum_new;
    acc_t psum_out;

    always_ff @(posedge clk)
    begin
        if (bias_we)
            bias_mem[bias_addr] <= bias_data;
    end

    ////////////////////////////////////////
    // channel accumulation
    ////////////////////////////////////////
    // first channel starts from the bias, later ones from the stored partial
    assign psum_base = acc.first_chan ? bias_mem[acc.filt_idx] : ofm_mem[acc.ofm_addr];
    assign psum_new  = psum_base + sum;

    // relu once the last channel is in
    assign psum_out = (acc.last_chan && psum_new[ACC_W-1]) ? '0 : psum_new;

    always_ff @(posedge clk)
    begin
        if (acc.psum_we)
            ofm_mem[acc.ofm_addr] <= psum_out;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            ofm_rd_data <= '0;
        else
            ofm_rd_data <= ofm_mem[ofm_rd_addr];   // registered read port
    end

endmodule

`default_nettype wire

/* src/window_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module window_buffer
    import conv_geom_pkg::*;
    import conv_data_pkg::*;
(
    input  wire         clk,
    input  wire         reset,
    input  wire pixel_t shift_in,
    conv_ctrl_if.window win,
    output pixel_t      window [KERNEL_TAPS]
);

    pixel_t line_sr [FILL_COUNT];   // [0] is the newest pixel

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < FILL_COUNT; i++)
                line_sr[i] <= '0;
        end
        else if (win.shift_en)
        begin
            line_sr[0] <= shift_in;
            for (int i = 1; i < FILL_COUNT; i++)
                line_sr[i] <= line_sr[i-1];
        end
    end

    ////////////////////////////////////////
    // window taps
    ////////////////////////////////////////
    // rows are one map line apart along the chain, bottom right tap at the head
    always_comb
    begin
        for (int r = 0; r < KERNEL_SIZE; r++)
        begin
            for (int c = 0; c < KERNEL_SIZE; c++)
            begin
                window[r*KERNEL_SIZE + c] =
                    line_sr[(KERNEL_SIZE-1-r)*IFM_SIZE + (KERNEL_SIZE-1-c)];
            end
        end
    end

endmodule

`default_nettype wire
